// ==== tb.f ====
source/bp_axil_pkg.sv
source/bedrock_reg_slice.sv
source/axil_req_intake.sv
source/mem_fwd_encoder.sv
source/axil_resp_return.sv
source/bp_me_axil_client.sv
tests/tb_mem_responder.sv
tests/tb_axil_client.sv

// ==== tests/tb_axil_client.sv ====
`default_nettype none

module tb_axil_client
  import bp_axil_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int clk_period_lp = 4;
  localparam int num_txn_lp    = 68;
  localparam logic [7:0] bad_strb_lp [6] = '{8'h00, 8'h05, 8'h06, 8'h3c, 8'h07, 8'h81};

  logic                          clk = 1'b0;
  logic                          rst_n;
  logic [lce_id_width_lp-1:0]    lce_id;
  logic [did_width_lp-1:0]       did;
  logic [axil_addr_width_lp-1:0] awaddr;
  logic                          awvalid;
  logic                          awready;
  logic [axil_data_width_lp-1:0] wdata;
  logic [axil_mask_width_lp-1:0] wstrb;
  logic                          wvalid;
  logic                          wready;
  axil_resp_e                    bresp;
  logic                          bvalid;
  logic                          bready;
  logic [axil_addr_width_lp-1:0] araddr;
  logic                          arvalid;
  logic                          arready;
  logic [axil_data_width_lp-1:0] rdata;
  axil_resp_e                    rresp;
  logic                          rvalid;
  logic                          rready;
  bp_mem_fwd_s                   mem_fwd;
  logic                          mem_fwd_v;
  logic                          mem_fwd_ready;
  bp_mem_rev_s                   mem_rev;
  logic                          mem_rev_v;
  logic                          mem_rev_ready;

  logic [7:0]                    model_mem [0:127];
  bp_mem_fwd_header_s            exp_fwd_q [$];
  logic [31:0]                   written_q [$];
  logic [31:0]                   lfsr_q = 32'hee6c;
  string                         test_name = "reset";

  always #(clk_period_lp / 2) clk = ~clk;

  bp_me_axil_client u_bp_me_axil_client (
    .clk_i               (clk),
    .rst_n_i             (rst_n),
    .lce_id_i            (lce_id),
    .did_i               (did),
    .mem_fwd_o           (mem_fwd),
    .mem_fwd_v_o         (mem_fwd_v),
    .mem_fwd_ready_and_i (mem_fwd_ready),
    .mem_rev_i           (mem_rev),
    .mem_rev_v_i         (mem_rev_v),
    .mem_rev_ready_and_o (mem_rev_ready),
    .s_axil_awaddr_i     (awaddr),
    .s_axil_awprot_i     (3'b010),
    .s_axil_awvalid_i    (awvalid),
    .s_axil_awready_o    (awready),
    .s_axil_wdata_i      (wdata),
    .s_axil_wstrb_i      (wstrb),
    .s_axil_wvalid_i     (wvalid),
    .s_axil_wready_o     (wready),
    .s_axil_bresp_o      (bresp),
    .s_axil_bvalid_o     (bvalid),
    .s_axil_bready_i     (bready),
    .s_axil_araddr_i     (araddr),
    .s_axil_arprot_i     (3'b010),
    .s_axil_arvalid_i    (arvalid),
    .s_axil_arready_o    (arready),
    .s_axil_rdata_o      (rdata),
    .s_axil_rresp_o      (rresp),
    .s_axil_rvalid_o     (rvalid),
    .s_axil_rready_i     (rready)
  );

  tb_mem_responder u_mem (
    .clk_i           (clk),
    .rst_n_i         (rst_n),
    .fwd_i           (mem_fwd),
    .fwd_v_i         (mem_fwd_v),
    .fwd_ready_and_o (mem_fwd_ready),
    .rev_o           (mem_rev),
    .rev_v_o         (mem_rev_v),
    .rev_ready_and_i (mem_rev_ready)
  );

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
      r = {r[30:0], lfsr_q[0]};
    end
    return r;
  endfunction

  task automatic report_failure(input string what);
    $display("error in %s: %s", test_name, what);
    $display("ERRORS FOUND");
    $fatal(1, "%s", what);
  endtask

  task automatic check_fwd_header(input string name, input bp_mem_fwd_header_s exp_h,
                                  input bp_mem_fwd_header_s act_h);
    if (act_h !== exp_h) begin
      $display("mismatch %s: expected %h actual %h", name, exp_h, act_h);
      $display("ERRORS FOUND");
      $fatal(1, "forward header mismatch");
    end
  endtask

  task automatic check_resp(input string name, input axil_resp_e exp_r, input axil_resp_e act_r);
    if (act_r !== exp_r) begin
      $display("mismatch %s: expected %b actual %b", name, exp_r, act_r);
      $display("ERRORS FOUND");
      $fatal(1, "response code mismatch");
    end
  endtask

  task automatic check_data(input string name, input logic [63:0] exp_d, input logic [63:0] act_d);
    if (act_d !== exp_d) begin
      $display("mismatch %s: expected %h actual %h", name, exp_d, act_d);
      $display("ERRORS FOUND");
      $fatal(1, "read data mismatch");
    end
  endtask

  // Legal strobes are naturally aligned groups of 1, 2, 4 or 8 bytes
  function automatic logic decode_strobe(input logic [7:0] strb, output bedrock_msg_size_e size,
                                         output logic [2:0] low);
    int n;
    n    = $countones(strb);
    low  = 3'd0;
    size = size_1;
    for (int i = 7; i >= 0; i--) begin
      if (strb[i]) begin
        low = 3'(i);
      end
    end
    if (!(n inside {1, 2, 4, 8})) begin
      return 1'b0;
    end
    size = bedrock_msg_size_e'($clog2(n));
    return (low % n == 0) && (strb == 8'(((1 << n) - 1) << low));
  endfunction

  function automatic axil_resp_e model_write(input logic [31:0] addr, input logic [63:0] data,
                                             input logic [7:0] strb);
    bedrock_msg_size_e  size;
    logic [2:0]         low;
    bp_mem_fwd_header_s h;
    if (!decode_strobe(strb, size, low)) begin
      return slverr;
    end
    h = '{uc_wr, {addr[31:3], low}, size, lce_id, did};
    exp_fwd_q.push_back(h);
    for (int i = 0; i < 8; i++) begin
      if (strb[i]) begin
        model_mem[{addr[6:3], 3'(i)}] = data[8*i +: 8];
      end
    end
    return okay;
  endfunction

  function automatic logic [63:0] model_read(input logic [31:0] addr);
    bp_mem_fwd_header_s h;
    logic [63:0]        d;
    h = '{uc_rd, {addr[31:3], 3'b000}, size_8, lce_id, did};
    exp_fwd_q.push_back(h);
    for (int i = 0; i < 8; i++) begin
      d[8*i +: 8] = model_mem[{addr[6:3], 3'(i)}];
    end
    return d;
  endfunction

  task automatic wait_b(input axil_resp_e exp_resp);
    logic fired;
    fired = 1'b0;
    while (!fired) begin
      bready = rand_bits(2) != 0;
      @(negedge clk);
      if (rvalid) report_failure("read response during a write");
      if (bvalid && bready) begin
        check_resp(test_name, exp_resp, bresp);
        fired = 1'b1;
      end
      @(posedge clk);
      #1;
    end
    bready = 1'b0;
    if (bvalid) report_failure("write response repeated");
  endtask

  task automatic wait_r(input logic [63:0] exp_data);
    logic fired;
    fired = 1'b0;
    while (!fired) begin
      rready = rand_bits(2) != 0;
      @(negedge clk);
      if (bvalid) report_failure("write response during a read");
      if (rvalid && rready) begin
        check_resp(test_name, okay, rresp);
        check_data(test_name, exp_data, rdata);
        fired = 1'b1;
      end
      @(posedge clk);
      #1;
    end
    rready = 1'b0;
    if (rvalid) report_failure("read response repeated");
  endtask

  task automatic axil_write(input logic [31:0] addr, input logic [63:0] data,
                            input logic [7:0] strb);
    axil_resp_e exp_resp;
    exp_resp = model_write(addr, data, strb);
    awaddr   = addr;
    wdata    = data;
    wstrb    = strb;
    awvalid  = 1'b1;
    wvalid   = 1'b1;
    do @(negedge clk); while (!awready);
    if (!wready) report_failure("awready without wready");
    @(posedge clk);
    #1;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    wait_b(exp_resp);
  endtask

  task automatic axil_read(input logic [31:0] addr);
    logic [63:0] exp_data;
    exp_data = model_read(addr);
    araddr   = addr;
    arvalid  = 1'b1;
    do @(negedge clk); while (!arready);
    @(posedge clk);
    #1;
    arvalid = 1'b0;
    wait_r(exp_data);
  endtask

  // Write and read offered together, the write must go first
  task automatic write_with_read(input logic [31:0] addr, input logic [63:0] data);
    axil_resp_e  exp_resp;
    logic [63:0] exp_data;
    exp_resp = model_write(addr, data, 8'hff);
    exp_data = model_read(addr);
    awaddr   = addr;
    wdata    = data;
    wstrb    = 8'hff;
    araddr   = addr;
    awvalid  = 1'b1;
    wvalid   = 1'b1;
    arvalid  = 1'b1;
    do @(negedge clk); while (!awready);
    if (arready) report_failure("read accepted in the same cycle as a write");
    @(posedge clk);
    #1;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    wait_b(exp_resp);
    do @(negedge clk); while (!arready);
    @(posedge clk);
    #1;
    arvalid = 1'b0;
    wait_r(exp_data);
  endtask

  task automatic read_written();
    while (written_q.size() != 0) begin
      axil_read(written_q.pop_front());
    end
  endtask

  // Every forward message must match the oldest expected header
  always @(negedge clk) begin
    if (rst_n && mem_fwd_v && mem_fwd_ready) begin
      if (exp_fwd_q.size() == 0) begin
        report_failure("forward message sent with none expected");
      end else begin
        check_fwd_header(test_name, exp_fwd_q.pop_front(), mem_fwd.header);
      end
    end
  end

  initial begin : watchdog
    #((num_txn_lp * 200 + 10) * clk_period_lp);
    $display("timeout: transactions did not complete in time");
    $display("ERRORS FOUND");
    $fatal(1, "watchdog expired");
  end

  initial begin : stimulus
    logic [31:0] a;
    logic [7:0]  strb;
    int          n;
    rst_n   = 1'b0;
    lce_id  = 4'h5;
    did     = 3'h2;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    for (int i = 0; i < 128; i++) begin
      model_mem[i] = 8'(i * 37 + 11);
    end
    repeat (3) @(posedge clk);
    if (mem_rev_ready || awready || wready || arready || bvalid || rvalid || mem_fwd_v) begin
      report_failure("ready or valid output high during reset");
    end
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    if (mem_rev_ready || awready || wready || arready || bvalid || rvalid || mem_fwd_v) begin
      report_failure("ready or valid output high before any request");
    end
    @(posedge clk);
    #1;

    test_name = "full_write";
    for (int i = 0; i < 6; i++) begin
      a = rand_bits(32);
      written_q.push_back(a);
      axil_write(a, {rand_bits(32), rand_bits(32)}, 8'hff);
    end
    read_written();

    test_name = "narrow_write";
    for (int i = 0; i < 6; i++) begin
      n    = 1 << (i % 3);
      strb = 8'(((1 << n) - 1) << ((rand_bits(3) / n) * n));
      a    = rand_bits(32);
      written_q.push_back(a);
      axil_write(a, {rand_bits(32), rand_bits(32)}, strb);
    end
    read_written();

    test_name = "illegal_strobe";
    foreach (bad_strb_lp[i]) begin
      a = rand_bits(32);
      written_q.push_back(a);
      axil_write(a, {rand_bits(32), rand_bits(32)}, bad_strb_lp[i]);
    end
    read_written();

    test_name = "write_then_read";
    write_with_read(rand_bits(32), {rand_bits(32), rand_bits(32)});

    test_name = "random_mix";
    for (int i = 0; i < 30; i++) begin
      a = rand_bits(32);
      if (rand_bits(1) != 0) begin
        axil_read(a);
      end else if (rand_bits(1) != 0) begin
        axil_write(a, {rand_bits(32), rand_bits(32)}, 8'hff);
      end else begin
        axil_write(a, {rand_bits(32), rand_bits(32)}, 8'(rand_bits(8)));
      end
    end

    repeat (4) @(posedge clk);
    if (exp_fwd_q.size() != 0) begin
      $display("error: %0d expected forward messages never appeared", exp_fwd_q.size());
      $display("ERRORS FOUND");
      $fatal(1, "missing forward messages");
    end else begin
      $display("NO ERRORS");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== tests/tb_mem_responder.sv ====
`default_nettype none

module tb_mem_responder
  import bp_axil_pkg::*;
(
  input  wire logic        clk_i,
  input  wire logic        rst_n_i,

  input  wire bp_mem_fwd_s fwd_i,
  input  wire logic        fwd_v_i,
  output logic             fwd_ready_and_o,

  output bp_mem_rev_s      rev_o,
  output logic             rev_v_o,
  input  wire logic        rev_ready_and_i
);
  timeunit 1ns;
  timeprecision 100ps;

  // 16 words of 8 bytes
  logic [7:0]  mem [0:127];
  logic [31:0] lfsr_q = 32'hee6c;

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
      r = {r[30:0], lfsr_q[0]};
    end
    return r;
  endfunction

  // Apply a write or fetch a read word, then build the reverse message
  task automatic serve(input bp_mem_fwd_s msg);
    logic [7:0] mask;
    logic [6:0] base;
    base = {msg.header.addr[6:3], 3'b000};
    mask = 8'(((1 << (1 << msg.header.size)) - 1) << msg.header.addr[2:0]);
    rev_o.header = bp_mem_rev_header_s'(msg.header);
    rev_o.data   = '0;
    for (int i = 0; i < 8; i++) begin
      if (msg.header.msg_type == uc_wr && mask[i]) begin
        mem[base + i] = msg.data[8*i +: 8];
      end
      if (msg.header.msg_type == uc_rd) begin
        rev_o.data[8*i +: 8] = mem[base + i];
      end
    end
  endtask

  initial begin : respond
    bp_mem_fwd_s msg;
    for (int a = 0; a < 128; a++) begin
      mem[a] = 8'(a * 37 + 11);
    end
    fwd_ready_and_o = 1'b0;
    rev_v_o         = 1'b0;
    rev_o           = '0;
    @(posedge rst_n_i);
    forever begin
      @(posedge clk_i);
      #1;
      fwd_ready_and_o = rand_bits(2) != 0;
      @(negedge clk_i);
      if (fwd_v_i && fwd_ready_and_o) begin
        msg = fwd_i;
        @(posedge clk_i);
        #1;
        fwd_ready_and_o = 1'b0;
        // Random memory latency of 0 to 5 cycles
        repeat (rand_bits(3) % 6) begin
          @(posedge clk_i);
          #1;
        end
        serve(msg);
        rev_v_o = 1'b1;
        do @(negedge clk_i); while (!rev_ready_and_i);
        @(posedge clk_i);
        #1;
        rev_v_o = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/bp_me_axil_client.sv ====
`default_nettype none

module bp_me_axil_client
  import bp_axil_pkg::*;
(
  input  wire logic                          clk_i,
  input  wire logic                          rst_n_i,

  input  wire logic [lce_id_width_lp-1:0]    lce_id_i,
  input  wire logic [did_width_lp-1:0]       did_i,

  // BedRock memory forward and reverse
  output bp_mem_fwd_s                        mem_fwd_o,
  output logic                               mem_fwd_v_o,
  input  wire logic                          mem_fwd_ready_and_i,

  input  wire bp_mem_rev_s                   mem_rev_i,
  input  wire logic                          mem_rev_v_i,
  output logic                               mem_rev_ready_and_o,

  // AXI-Lite subordinate, prot is accepted and ignored
  input  wire logic [axil_addr_width_lp-1:0] s_axil_awaddr_i,
  input  wire logic [2:0]                    s_axil_awprot_i,
  input  wire logic                          s_axil_awvalid_i,
  output logic                               s_axil_awready_o,

  input  wire logic [axil_data_width_lp-1:0] s_axil_wdata_i,
  input  wire logic [axil_mask_width_lp-1:0] s_axil_wstrb_i,
  input  wire logic                          s_axil_wvalid_i,
  output logic                               s_axil_wready_o,

  output axil_resp_e                         s_axil_bresp_o,
  output logic                               s_axil_bvalid_o,
  input  wire logic                          s_axil_bready_i,

  input  wire logic [axil_addr_width_lp-1:0] s_axil_araddr_i,
  input  wire logic [2:0]                    s_axil_arprot_i,
  input  wire logic                          s_axil_arvalid_i,
  output logic                               s_axil_arready_o,

  output logic [axil_data_width_lp-1:0]      s_axil_rdata_o,
  output axil_resp_e                         s_axil_rresp_o,
  output logic                               s_axil_rvalid_o,
  input  wire logic                          s_axil_rready_i
);

  axil_req_s   req;
  logic        req_v;
  logic        req_ready_and;
  bp_mem_fwd_s fwd;
  logic        fwd_v;
  logic        fwd_ready_and;
  logic        err_v;
  bp_mem_rev_s rev;
  logic        rev_v;
  logic        rev_ready_and;
  logic        done;

  axil_req_intake u_intake (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .awaddr_i        (s_axil_awaddr_i),
    .awvalid_i       (s_axil_awvalid_i),
    .awready_o       (s_axil_awready_o),
    .wdata_i         (s_axil_wdata_i),
    .wstrb_i         (s_axil_wstrb_i),
    .wvalid_i        (s_axil_wvalid_i),
    .wready_o        (s_axil_wready_o),
    .araddr_i        (s_axil_araddr_i),
    .arvalid_i       (s_axil_arvalid_i),
    .arready_o       (s_axil_arready_o),
    .done_i          (done),
    .req_o           (req),
    .req_v_o         (req_v),
    .req_ready_and_i (req_ready_and)
  );

  mem_fwd_encoder u_encoder (
    .req_i           (req),
    .req_v_i         (req_v),
    .req_ready_and_o (req_ready_and),
    .lce_id_i        (lce_id_i),
    .did_i           (did_i),
    .fwd_o           (fwd),
    .fwd_v_o         (fwd_v),
    .fwd_ready_and_i (fwd_ready_and),
    .err_v_o         (err_v)
  );

  bedrock_reg_slice #(.payload_t(bp_mem_fwd_s)) u_fwd_slice (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .data_i      (fwd),
    .v_i         (fwd_v),
    .ready_and_o (fwd_ready_and),
    .data_o      (mem_fwd_o),
    .v_o         (mem_fwd_v_o),
    .ready_and_i (mem_fwd_ready_and_i)
  );

  bedrock_reg_slice #(.payload_t(bp_mem_rev_s)) u_rev_slice (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .data_i      (mem_rev_i),
    .v_i         (mem_rev_v_i),
    .ready_and_o (mem_rev_ready_and_o),
    .data_o      (rev),
    .v_o         (rev_v),
    .ready_and_i (rev_ready_and)
  );

  axil_resp_return u_return (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .rev_i           (rev),
    .rev_v_i         (rev_v),
    .rev_ready_and_o (rev_ready_and),
    .err_v_i         (err_v),
    .bresp_o         (s_axil_bresp_o),
    .bvalid_o        (s_axil_bvalid_o),
    .bready_i        (s_axil_bready_i),
    .rdata_o         (s_axil_rdata_o),
    .rresp_o         (s_axil_rresp_o),
    .rvalid_o        (s_axil_rvalid_o),
    .rready_i        (s_axil_rready_i),
    .done_o          (done)
  );

endmodule

`default_nettype wire

// ==== source/axil_resp_return.sv ====
`default_nettype none

module axil_resp_return
  import bp_axil_pkg::*;
(
  input  wire logic                     clk_i,
  input  wire logic                     rst_n_i,

  input  wire bp_mem_rev_s              rev_i,
  input  wire logic                     rev_v_i,
  output logic                          rev_ready_and_o,

  input  wire logic                     err_v_i,

  // Write response channel
  output axil_resp_e                    bresp_o,
  output logic                          bvalid_o,
  input  wire logic                     bready_i,

  // Read data channel
  output logic [axil_data_width_lp-1:0] rdata_o,
  output axil_resp_e                    rresp_o,
  output logic                          rvalid_o,
  input  wire logic                     rready_i,

  output logic                          done_o
);

  logic                          bvalid_q;
  logic                          rvalid_q;
  axil_resp_e                    resp_q;
  logic [axil_data_width_lp-1:0] data_q;
  logic                          rev_take;
  logic                          b_done;
  logic                          r_done;

  // One response register, so accept only when it is empty
  assign rev_ready_and_o = ~bvalid_q & ~rvalid_q;
  assign rev_take        = rev_v_i & rev_ready_and_o;

  assign b_done = bvalid_q & bready_i;
  assign r_done = rvalid_q & rready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      if (err_v_i) begin
        bvalid_q <= 1'b1;
      end else if (rev_take && rev_i.header.msg_type == uc_wr) begin
        bvalid_q <= 1'b1;
      end else if (rev_take) begin
        rvalid_q <= 1'b1;
      end
      if (b_done) begin
        bvalid_q <= 1'b0;
      end
      if (r_done) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  // Response code and read data
  always_ff @(posedge clk_i) begin
    if (err_v_i) begin
      resp_q <= slverr;
    end else if (rev_take) begin
      resp_q <= okay;
      data_q <= rev_i.data;
    end
  end

  assign bvalid_o = bvalid_q;
  assign bresp_o  = resp_q;
  assign rvalid_o = rvalid_q;
  assign rresp_o  = resp_q;
  assign rdata_o  = data_q;

  assign done_o = b_done | r_done;

  a_single_resp_channel: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(bvalid_o && rvalid_o));

endmodule

`default_nettype wire

// ==== source/mem_fwd_encoder.sv ====
`default_nettype none

module mem_fwd_encoder
  import bp_axil_pkg::*;
(
  input  wire axil_req_s                  req_i,
  input  wire logic                       req_v_i,
  output logic                            req_ready_and_o,

  input  wire logic [lce_id_width_lp-1:0] lce_id_i,
  input  wire logic [did_width_lp-1:0]    did_i,

  output bp_mem_fwd_s                     fwd_o,
  output logic                            fwd_v_o,
  input  wire logic                       fwd_ready_and_i,

  // Illegal write, answered locally with SLVERR
  output logic                            err_v_o
);

  logic                            strobe_legal;
  logic                            is_err;
  bedrock_msg_size_e               wr_size;
  logic [axil_offset_width_lp-1:0] wr_offset;

  // Legal strobes are naturally aligned groups of 1, 2, 4 or 8 bytes
  always_comb begin
    strobe_legal = 1'b1;
    wr_size      = size_8;
    case (req_i.strobe)
      8'h01, 8'h02, 8'h04, 8'h08,
      8'h10, 8'h20, 8'h40, 8'h80: wr_size = size_1;
      8'h03, 8'h0c, 8'h30, 8'hc0: wr_size = size_2;
      8'h0f, 8'hf0:               wr_size = size_4;
      8'hff:                      wr_size = size_8;
      default:                    strobe_legal = 1'b0;
    endcase
  end

  // Byte offset of the lowest strobe bit
  always_comb begin
    wr_offset = '0;
    for (int i = axil_mask_width_lp - 1; i >= 0; i--) begin
      if (req_i.strobe[i]) begin
        wr_offset = axil_offset_width_lp'(i);
      end
    end
  end

  assign is_err = req_i.write & ~strobe_legal;

  always_comb begin
    fwd_o               = '0;
    fwd_o.header.lce_id = lce_id_i;
    fwd_o.header.did    = did_i;
    fwd_o.data          = req_i.data;
    if (req_i.write) begin
      fwd_o.header.msg_type = uc_wr;
      fwd_o.header.size     = wr_size;
      fwd_o.header.addr     = {req_i.addr[axil_addr_width_lp-1:axil_offset_width_lp], wr_offset};
    end else begin
      // Reads are always a full aligned word
      fwd_o.header.msg_type = uc_rd;
      fwd_o.header.size     = size_8;
      fwd_o.header.addr     = {req_i.addr[axil_addr_width_lp-1:axil_offset_width_lp],
                               axil_offset_width_lp'(0)};
    end
  end

  assign fwd_v_o         = req_v_i & ~is_err;
  assign err_v_o         = req_v_i & is_err;
  // An illegal write is dropped here without waiting on the slice
  assign req_ready_and_o = is_err | fwd_ready_and_i;

endmodule

`default_nettype wire

// ==== source/axil_req_intake.sv ====
`default_nettype none

module axil_req_intake
  import bp_axil_pkg::*;
(
  input  wire logic                          clk_i,
  input  wire logic                          rst_n_i,

  // Write address channel
  input  wire logic [axil_addr_width_lp-1:0] awaddr_i,
  input  wire logic                          awvalid_i,
  output logic                               awready_o,

  // Write data channel
  input  wire logic [axil_data_width_lp-1:0] wdata_i,
  input  wire logic [axil_mask_width_lp-1:0] wstrb_i,
  input  wire logic                          wvalid_i,
  output logic                               wready_o,

  // Read address channel
  input  wire logic [axil_addr_width_lp-1:0] araddr_i,
  input  wire logic                          arvalid_i,
  output logic                               arready_o,

  // Response side reports the end of the transaction
  input  wire logic                          done_i,

  output axil_req_s                          req_o,
  output logic                               req_v_o,
  input  wire logic                          req_ready_and_i
);

  logic      busy_q;
  logic      req_v_q;
  axil_req_s req_q;
  logic      take_w;
  logic      take_r;

  // AW and W are taken together, and a write beats a read
  assign take_w = ~busy_q & awvalid_i & wvalid_i;
  assign take_r = ~busy_q & arvalid_i & ~(awvalid_i & wvalid_i);

  assign awready_o = take_w;
  assign wready_o  = take_w;
  assign arready_o = take_r;

  // Busy spans from the handshake until the B or R handshake
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
    end else if (take_w || take_r) begin
      busy_q <= 1'b1;
    end else if (done_i) begin
      busy_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      req_v_q <= 1'b0;
    end else if (take_w || take_r) begin
      req_v_q <= 1'b1;
    end else if (req_ready_and_i) begin
      req_v_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (take_w) begin
      req_q.write  <= 1'b1;
      req_q.addr   <= awaddr_i;
      req_q.data   <= wdata_i;
      req_q.strobe <= wstrb_i;
    end else if (take_r) begin
      req_q.write  <= 1'b0;
      req_q.addr   <= araddr_i;
      req_q.data   <= '0;
      req_q.strobe <= '1;
    end
  end

  assign req_o   = req_q;
  assign req_v_o = req_v_q;

  // A response may only finish a request that was already handed on
  a_done_while_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    done_i |-> (busy_q && !req_v_q));

endmodule

`default_nettype wire

// ==== source/bedrock_reg_slice.sv ====
`default_nettype none

module bedrock_reg_slice #(
  parameter type payload_t = logic
) (
  input  wire logic     clk_i,
  input  wire logic     rst_n_i,

  input  wire payload_t data_i,
  input  wire logic     v_i,
  output logic          ready_and_o,

  output payload_t      data_o,
  output logic          v_o,
  input  wire logic     ready_and_i
);

  logic     full_q;
  logic     live_q;
  payload_t data_q;

  // Upstream stays blocked for the first cycle out of reset
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      live_q <= 1'b0;
    end else begin
      live_q <= 1'b1;
    end
  end

  // Empty or draining this cycle, so one transfer per cycle is sustained
  assign ready_and_o = live_q & (~full_q | ready_and_i);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      full_q <= 1'b0;
    end else if (v_i && ready_and_o) begin
      full_q <= 1'b1;
    end else if (ready_and_i) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (v_i && ready_and_o) begin
      data_q <= data_i;
    end
  end

  assign v_o    = full_q;
  assign data_o = data_q;

  // A stalled entry must not change under the consumer
  a_hold_when_stalled: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (v_o && !ready_and_i) |=> (v_o && $stable(data_o)));

endmodule

`default_nettype wire

// ==== source/bp_axil_pkg.sv ====
`default_nettype none

package bp_axil_pkg;

  // AXI-Lite side widths
  localparam int axil_addr_width_lp   = 32;
  localparam int axil_data_width_lp   = 64;
  localparam int axil_mask_width_lp   = axil_data_width_lp / 8;
  localparam int axil_offset_width_lp = $clog2(axil_mask_width_lp);

  // BedRock routing fields
  localparam int lce_id_width_lp = 4;
  localparam int did_width_lp    = 3;

  // Only the uncached subset of BedRock memory messages is used here
  typedef enum logic [3:0] {
    uc_rd = 4'b0010,
    uc_wr = 4'b0011
  } bedrock_mem_msg_e;

  // log2 of the access size in bytes
  typedef enum logic [2:0] {
    size_1 = 3'b000,
    size_2 = 3'b001,
    size_4 = 3'b010,
    size_8 = 3'b011
  } bedrock_msg_size_e;

  typedef enum logic [1:0] {
    okay   = 2'b00,
    slverr = 2'b10
  } axil_resp_e;

  // One accepted AXI-Lite request, write or read
  typedef struct packed {
    logic                          write;
    logic [axil_addr_width_lp-1:0] addr;
    logic [axil_data_width_lp-1:0] data;
    logic [axil_mask_width_lp-1:0] strobe;
  } axil_req_s;

  typedef struct packed {
    bedrock_mem_msg_e              msg_type;
    logic [axil_addr_width_lp-1:0] addr;
    bedrock_msg_size_e             size;
    logic [lce_id_width_lp-1:0]    lce_id;
    logic [did_width_lp-1:0]       did;
  } bp_mem_fwd_header_s;

  // Reverse header mirrors the forward one
  typedef struct packed {
    bedrock_mem_msg_e              msg_type;
    logic [axil_addr_width_lp-1:0] addr;
    bedrock_msg_size_e             size;
    logic [lce_id_width_lp-1:0]    lce_id;
    logic [did_width_lp-1:0]       did;
  } bp_mem_rev_header_s;

  typedef struct packed {
    bp_mem_fwd_header_s            header;
    logic [axil_data_width_lp-1:0] data;
  } bp_mem_fwd_s;

  typedef struct packed {
    bp_mem_rev_header_s            header;
    logic [axil_data_width_lp-1:0] data;
  } bp_mem_rev_s;

endpackage

`default_nettype wire
